// File: src/ahb_pkg.sv
package ahb_pkg;

    // transfer type, driven by the master every cycle
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // transfer size, only up to a full word on this bus
    typedef enum logic [2:0]
    {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // slaves here only ever answer okay
    typedef enum logic
    {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    // address-phase bundle, 38 bits
    typedef struct packed
    {
        logic [31:0] haddr;
        htrans_t     htrans;
        logic        hwrite;
        hsize_t      hsize;
    } ahb_addr_t;

    // response bundle back to the master, 34 bits
    typedef struct packed
    {
        logic [31:0] hrdata;
        logic        hready;
        hresp_t      hresp;
    } ahb_resp_t;

    // nonseq and seq move data, idle and busy do not
    function automatic logic transfer_active(htrans_t htrans);
        return (htrans == NONSEQ) || (htrans == SEQ);
    endfunction

    // little endian byte lanes touched by a transfer
    function automatic logic [3:0] lane_mask(hsize_t hsize, logic [1:0] addr_lo);
        logic [3:0] mask;
        case (hsize)
            BYTE:    mask = 4'b0001 << addr_lo;
            HALF:    mask = addr_lo[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

// File: src/soc_map_pkg.sv
package soc_map_pkg;

    // regions are matched on the upper address half only
    localparam int region_match_bits = 16;

    // region bases, each one spans 64 KB
    localparam logic [31:0] ram0_base = 32'h0000_0000;
    localparam logic [31:0] ram1_base = 32'h0001_0000;
    localparam logic [31:0] gpio_base = 32'h1F80_0000;

    // gpio register offsets within its region
    localparam logic [31-region_match_bits:0] gpio_out_offset = 'h0;
    localparam logic [31-region_match_bits:0] gpio_in_offset  = 'h4;

    // one-hot slave select, all zero when nothing matches
    typedef struct packed
    {
        logic ram0;
        logic ram1;
        logic gpio;
    } slave_sel_t;

endpackage

// File: src/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
#(
    parameter int addr_width = 6
)
(
    input  logic                  HCLK,
    input  logic [addr_width-1:0] read_addr,
    input  logic [addr_width-1:0] write_addr,
    input  logic [7:0]            write_data,
    input  logic                  write_enable,
    output logic [7:0]            read_data
);

    // one byte lane, 2**addr_width deep
    logic [7:0] mem [0:(1 << addr_width)-1];

    // write port
    always_ff @(posedge HCLK)
    begin
        if (write_enable)
        begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read port
    // same-address collision gives the old byte
    always_ff @(posedge HCLK)
    begin
        read_data <= mem[read_addr];
    end

endmodule

// File: src/ahb_ram_slave.sv
`timescale 1ns/1ps

module ahb_ram_slave
#(
    parameter int ram_addr_width = 6
)
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic               hsel,
    input  ahb_pkg::ahb_addr_t ahb_addr,
    input  logic [31:0]        hwdata,
    output logic [31:0]        rdata
);

    // address phase held over into the data phase
    ahb_pkg::ahb_addr_t addr_dly;
    logic               sel_dly;

    logic [ram_addr_width-1:0] read_word;
    logic [ram_addr_width-1:0] write_word;
    logic                      write_active;
    logic [3:0]                write_mask;

    // forwarding state for a read right behind a write
    logic [3:0]  fwd_mask;
    logic [31:0] fwd_data;
    logic [31:0] ram_rdata;

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            addr_dly <= '0;
            sel_dly  <= 1'b0;
        end
        else
        begin
            addr_dly <= ahb_addr;
            sel_dly  <= hsel;
        end
    end

    // reads go out in the address phase
    assign read_word  = ahb_addr.haddr[ram_addr_width+1:2];
    // writes land at the end of the data phase
    assign write_word = addr_dly.haddr[ram_addr_width+1:2];

    assign write_active = sel_dly && addr_dly.hwrite &&
                          ahb_pkg::transfer_active(addr_dly.htrans);

    // lanes to update, none unless a real write is in its data phase
    assign write_mask = write_active ?
                        ahb_pkg::lane_mask(addr_dly.hsize, addr_dly.haddr[1:0]) : 4'b0000;

    // ram hands back the stale word on a same-word collision
    // so remember which lanes were written
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            fwd_mask <= 4'b0000;
        end
        else if (read_word == write_word)
        begin
            fwd_mask <= write_mask;
        end
        else
        begin
            fwd_mask <= 4'b0000;
        end
    end

    // written bytes, only looked at through fwd_mask
    always_ff @(posedge HCLK)
    begin
        fwd_data <= hwdata;
    end

    for (genvar i = 0; i < 4; i++)
    begin : gen_lane
        dual_port_ram
        #(
            .addr_width   (ram_addr_width)
        )
        lane_inst
        (
            .HCLK         (HCLK),
            .read_addr    (read_word),
            .write_addr   (write_word),
            .write_data   (hwdata[i*8 +: 8]),
            .write_enable (write_mask[i]),
            .read_data    (ram_rdata[i*8 +: 8])
        );

        // fresh byte wins over the memory output
        assign rdata[i*8 +: 8] = fwd_mask[i] ? fwd_data[i*8 +: 8] : ram_rdata[i*8 +: 8];
    end

endmodule

// File: src/ahb_gpio_slave.sv
`timescale 1ns/1ps

module ahb_gpio_slave
#(
    parameter int gpio_width = 16
)
(
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  hsel,
    input  ahb_pkg::ahb_addr_t    ahb_addr,
    input  logic [31:0]           hwdata,
    input  logic [gpio_width-1:0] gpio_in,
    output logic [31:0]           rdata,
    output logic [gpio_width-1:0] gpio_out
);

    // top bit of the offset within the region
    localparam int off_msb = 31 - soc_map_pkg::region_match_bits;

    ahb_pkg::ahb_addr_t addr_dly;
    logic               sel_dly;

    logic                  write_active;
    logic [3:0]            write_mask;
    logic [31:0]           out_merged;
    logic [31:0]           read_value;
    logic [gpio_width-1:0] gpio_sync1;
    logic [gpio_width-1:0] gpio_sync2;

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            addr_dly <= '0;
            sel_dly  <= 1'b0;
        end
        else
        begin
            addr_dly <= ahb_addr;
            sel_dly  <= hsel;
        end
    end

    // only the output register takes writes
    assign write_active = sel_dly && addr_dly.hwrite &&
                          ahb_pkg::transfer_active(addr_dly.htrans) &&
                          (addr_dly.haddr[off_msb:2] == soc_map_pkg::gpio_out_offset[off_msb:2]);

    assign write_mask = write_active ?
                        ahb_pkg::lane_mask(addr_dly.hsize, addr_dly.haddr[1:0]) : 4'b0000;

    // next output value, byte by byte
    always_comb
    begin
        out_merged = 32'(gpio_out);
        for (int i = 0; i < 4; i++)
        begin
            if (write_mask[i])
            begin
                out_merged[i*8 +: 8] = hwdata[i*8 +: 8];
            end
        end
    end

    // output register and the two-flop input synchronizer
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            gpio_out   <= '0;
            gpio_sync1 <= '0;
            gpio_sync2 <= '0;
        end
        else
        begin
            gpio_out   <= out_merged[gpio_width-1:0];
            gpio_sync1 <= gpio_in;
            gpio_sync2 <= gpio_sync1;
        end
    end

    // register picked by the current address phase
    // out reads the merged value so a read right after a write sees it
    always_comb
    begin
        read_value = 32'h0;
        if (ahb_addr.haddr[off_msb:2] == soc_map_pkg::gpio_out_offset[off_msb:2])
        begin
            read_value = 32'(out_merged[gpio_width-1:0]);
        end
        else if (ahb_addr.haddr[off_msb:2] == soc_map_pkg::gpio_in_offset[off_msb:2])
        begin
            read_value = 32'(gpio_sync2);
        end
    end

    // read data ready in the data phase
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            rdata <= 32'h0;
        end
        else if (hsel && !ahb_addr.hwrite && ahb_pkg::transfer_active(ahb_addr.htrans))
        begin
            rdata <= read_value;
        end
    end

endmodule

// File: src/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder
(
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  ahb_pkg::ahb_addr_t      ahb_addr,
    input  logic [31:0]             ram0_rdata,
    input  logic [31:0]             ram1_rdata,
    input  logic [31:0]             gpio_rdata,
    output soc_map_pkg::slave_sel_t sel,
    output ahb_pkg::ahb_resp_t      ahb_resp
);

    // upper address half that picks the region
    logic [soc_map_pkg::region_match_bits-1:0] region;

    // select of the transfer now in its data phase
    soc_map_pkg::slave_sel_t dphase_sel;
    logic [31:0]             hrdata;

    assign region = ahb_addr.haddr[31 -: soc_map_pkg::region_match_bits];

    // address-phase decode, combinational
    assign sel.ram0 = (region == soc_map_pkg::ram0_base[31 -: soc_map_pkg::region_match_bits]);
    assign sel.ram1 = (region == soc_map_pkg::ram1_base[31 -: soc_map_pkg::region_match_bits]);
    assign sel.gpio = (region == soc_map_pkg::gpio_base[31 -: soc_map_pkg::region_match_bits]);

    // idle and busy leave nothing selected in the next cycle
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            dphase_sel <= '0;
        end
        else if (ahb_pkg::transfer_active(ahb_addr.htrans))
        begin
            dphase_sel <= sel;
        end
        else
        begin
            dphase_sel <= '0;
        end
    end

    // data-phase read mux
    // unmapped or no transfer reads zero
    always_comb
    begin
        if (dphase_sel.ram0)
        begin
            hrdata = ram0_rdata;
        end
        else if (dphase_sel.ram1)
        begin
            hrdata = ram1_rdata;
        end
        else if (dphase_sel.gpio)
        begin
            hrdata = gpio_rdata;
        end
        else
        begin
            hrdata = 32'h0;
        end
    end

    // zero wait states, never an error
    assign ahb_resp.hrdata = hrdata;
    assign ahb_resp.hready = 1'b1;
    assign ahb_resp.hresp  = ahb_pkg::OKAY;

endmodule

// File: src/ahb_ram_subsystem.sv
`timescale 1ns/1ps

module ahb_ram_subsystem
#(
    // word address width of each ram, 14 at most
    parameter int ram_addr_width = 6,
    // gpio pin count, 1 to 32
    parameter int gpio_width     = 16
)
(
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  ahb_pkg::ahb_addr_t    ahb_addr,
    input  logic [31:0]           hwdata,
    input  logic [gpio_width-1:0] gpio_in,
    output ahb_pkg::ahb_resp_t    ahb_resp,
    output logic [gpio_width-1:0] gpio_out
);

    // address-phase select from the decoder
    soc_map_pkg::slave_sel_t sel;

    // data-phase read data from each slave
    logic [31:0] ram0_rdata;
    logic [31:0] ram1_rdata;
    logic [31:0] gpio_rdata;

    ahb_decoder decoder_inst
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .ahb_addr   (ahb_addr),
        .ram0_rdata (ram0_rdata),
        .ram1_rdata (ram1_rdata),
        .gpio_rdata (gpio_rdata),
        .sel        (sel),
        .ahb_resp   (ahb_resp)
    );

    // ram0 region
    ahb_ram_slave
    #(
        .ram_addr_width (ram_addr_width)
    )
    ram0_inst
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .hsel     (sel.ram0),
        .ahb_addr (ahb_addr),
        .hwdata   (hwdata),
        .rdata    (ram0_rdata)
    );

    // ram1 region, same slave at another base
    ahb_ram_slave
    #(
        .ram_addr_width (ram_addr_width)
    )
    ram1_inst
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .hsel     (sel.ram1),
        .ahb_addr (ahb_addr),
        .hwdata   (hwdata),
        .rdata    (ram1_rdata)
    );

    ahb_gpio_slave
    #(
        .gpio_width (gpio_width)
    )
    gpio_inst
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .hsel     (sel.gpio),
        .ahb_addr (ahb_addr),
        .hwdata   (hwdata),
        .gpio_in  (gpio_in),
        .rdata    (gpio_rdata),
        .gpio_out (gpio_out)
    );

endmodule

// File: verif/tb_ahb_ram_subsystem.sv
`timescale 1ns/1ps

module tb_ahb_ram_subsystem;

    localparam int ram_addr_width = 6;
    localparam int gpio_width     = 16;
    localparam int clk_period     = 20;
    localparam int num_transfers  = 3000;
    localparam int seed           = 58106;

    // both rams are filled word by word before the random part
    localparam int ram_words    = 1 << ram_addr_width;
    localparam int ram_bytes    = 4 * ram_words;
    localparam int init_cycles  = 2 * ram_words;
    localparam int total_cycles = init_cycles + num_transfers;
    // two clocks per transfer plus the fill and some slack
    localparam int timeout_ns   = 2 * num_transfers * clk_period + (init_cycles + 50) * clk_period;

    localparam logic [31:0] gpio_mask =
        (gpio_width == 32) ? 32'hFFFF_FFFF : ((32'd1 << gpio_width) - 32'd1);

    // region codes used by the model
    localparam logic [1:0] rgn_ram0 = 2'd0;
    localparam logic [1:0] rgn_ram1 = 2'd1;
    localparam logic [1:0] rgn_gpio = 2'd2;
    localparam logic [1:0] rgn_none = 2'd3;

    // one transfer from address phase to data phase
    typedef struct packed
    {
        ahb_pkg::ahb_addr_t    addr;
        logic [31:0]           wdata;
        logic [1:0]            region;
        logic [gpio_width-1:0] in_value;
    } txn_t;

    logic                  HCLK;
    logic                  HRESETn;
    ahb_pkg::ahb_addr_t    ahb_addr;
    logic [31:0]           hwdata;
    logic [gpio_width-1:0] gpio_in;
    ahb_pkg::ahb_resp_t    ahb_resp;
    logic [gpio_width-1:0] gpio_out;

    // reference model with bytes per ram and the output register
    logic [7:0]  ram_model [0:1][0:ram_bytes-1];
    logic [31:0] gpio_model;

    txn_t                  pending [$];
    txn_t                  dphase;
    logic                  dphase_valid;
    txn_t                  next_txn;
    txn_t                  last_gen;
    logic [gpio_width-1:0] in_level;
    int                    in_stable;
    int                    checks;
    int                    errors;

    ahb_ram_subsystem
    #(
        .ram_addr_width (ram_addr_width),
        .gpio_width     (gpio_width)
    )
    ahb_ram_subsystem_inst
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .ahb_addr (ahb_addr),
        .hwdata   (hwdata),
        .gpio_in  (gpio_in),
        .ahb_resp (ahb_resp),
        .gpio_out (gpio_out)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #(clk_period / 2) HCLK = ~HCLK;
    end

    // watchdog
    initial
    begin
        #(timeout_ns);
        $display("watchdog expired: run did not finish within %0d ns", timeout_ns);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic is_active(ahb_pkg::htrans_t htrans);
        return (htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ);
    endfunction

    // 64 KB regions picked by the upper address half
    function automatic logic [1:0] region_of(logic [31:0] haddr);
        if (haddr[31:16] == soc_map_pkg::ram0_base[31:16])
            return rgn_ram0;
        if (haddr[31:16] == soc_map_pkg::ram1_base[31:16])
            return rgn_ram1;
        if (haddr[31:16] == soc_map_pkg::gpio_base[31:16])
            return rgn_gpio;
        return rgn_none;
    endfunction

    // little endian lanes for an aligned transfer
    function automatic logic [3:0] byte_lanes(ahb_pkg::hsize_t hsize, logic [1:0] lo);
        logic [3:0] lanes;
        lanes = 4'b0000;
        if (hsize == ahb_pkg::BYTE)
            lanes[lo] = 1'b1;
        else if (hsize == ahb_pkg::HALF)
            lanes = lo[1] ? 4'b1100 : 4'b0011;
        else
            lanes = 4'b1111;
        return lanes;
    endfunction

    // fill value where every address bit counts
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return a ^ 32'hC3A5_0F96 ^ {a[7:0], a[15:8], a[23:16], a[31:24]};
    endfunction

    function automatic logic [31:0] expected_read(txn_t t);
        logic [31:0] w;
        int          base;
        w = 32'h0;
        base = int'(t.addr.haddr[ram_addr_width+1:2]) * 4;
        if (t.region == rgn_ram0 || t.region == rgn_ram1)
        begin
            for (int i = 0; i < 4; i++)
                w[i*8 +: 8] = ram_model[int'(t.region[0])][base + i];
        end
        else if (t.region == rgn_gpio)
        begin
            // output register at 0x0 and input register at 0x4
            if (t.addr.haddr[15:2] == 14'd0)
                w = gpio_model;
            else if (t.addr.haddr[15:2] == 14'd1)
                w = 32'(t.in_value);
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic apply_write(input txn_t t);
        logic [3:0] lanes;
        int         base;
        lanes = byte_lanes(t.addr.hsize, t.addr.haddr[1:0]);
        base = int'(t.addr.haddr[ram_addr_width+1:2]) * 4;
        for (int i = 0; i < 4; i++)
        begin
            if (lanes[i] && (t.region == rgn_ram0 || t.region == rgn_ram1))
                ram_model[int'(t.region[0])][base + i] = t.wdata[i*8 +: 8];
            if (lanes[i] && t.region == rgn_gpio && t.addr.haddr[15:2] == 14'd0)
                gpio_model[i*8 +: 8] = t.wdata[i*8 +: 8];
        end
        // pins above gpio_width do not exist
        gpio_model = gpio_model & gpio_mask;
    endtask

    // word writes covering ram0 then ram1
    task automatic make_fill(input int cyc, output txn_t t);
        int word;
        t = '0;
        word = cyc % ram_words;
        t.addr.haddr  = ((cyc < ram_words) ? soc_map_pkg::ram0_base : soc_map_pkg::ram1_base) |
                        32'(word * 4);
        t.addr.htrans = ahb_pkg::NONSEQ;
        t.addr.hwrite = 1'b1;
        t.addr.hsize  = ahb_pkg::WORD;
        t.wdata       = fill_word(t.addr.haddr);
        t.region      = region_of(t.addr.haddr);
    endtask

    task automatic gen_random(output txn_t t);
        int unsigned pick;
        logic [15:0] upper;
        logic [15:0] offset;
        t = '0;
        t.wdata = $urandom;
        pick = $urandom % 100;
        if (is_active(last_gen.addr.htrans) && last_gen.addr.hwrite &&
            last_gen.region inside {rgn_ram0, rgn_ram1} && pick < 30)
        begin
            // read straight back the word just written
            t.addr.haddr  = {last_gen.addr.haddr[31:2], 2'b00};
            t.addr.htrans = ahb_pkg::NONSEQ;
            t.addr.hsize  = ahb_pkg::WORD;
        end
        else
        begin
            pick = $urandom % 100;
            offset = 16'($urandom);
            if (pick < 35)
                t.addr.haddr = soc_map_pkg::ram0_base | {16'h0, offset};
            else if (pick < 70)
                t.addr.haddr = soc_map_pkg::ram1_base | {16'h0, offset};
            else if (pick < 85)
            begin
                // mostly the two real registers
                pick = $urandom % 10;
                if (pick < 6)
                    offset[15:2] = 14'd0;
                else if (pick < 9)
                    offset[15:2] = 14'd1;
                t.addr.haddr = soc_map_pkg::gpio_base | {16'h0, offset};
            end
            else
            begin
                // unmapped upper half between the ram1 and gpio regions
                upper = 16'h0002 + 16'($urandom % 32'h1F00);
                t.addr.haddr = {upper, offset};
            end
            pick = $urandom % 100;
            if (pick < 25)
                t.addr.htrans = ahb_pkg::IDLE;
            else if (pick < 30)
                t.addr.htrans = ahb_pkg::BUSY;
            else if (pick < 85)
                t.addr.htrans = ahb_pkg::NONSEQ;
            else
                t.addr.htrans = ahb_pkg::SEQ;
            t.addr.hwrite = ($urandom % 2) == 1;
            pick = t.addr.hwrite ? ($urandom % 3) : 2;
            if (pick == 0)
                t.addr.hsize = ahb_pkg::BYTE;
            else if (pick == 1)
            begin
                t.addr.hsize = ahb_pkg::HALF;
                t.addr.haddr[0] = 1'b0;
            end
            else
            begin
                t.addr.hsize = ahb_pkg::WORD;
                t.addr.haddr[1:0] = 2'b00;
            end
            // input register only once the synchronizer has settled
            if (region_of(t.addr.haddr) == rgn_gpio && !t.addr.hwrite &&
                t.addr.haddr[15:2] == 14'd1 && in_stable < 3)
                t.addr.haddr[2] = 1'b0;
        end
        t.region   = region_of(t.addr.haddr);
        t.in_value = in_level;
        last_gen   = t;
    endtask

    // response fields and gpio_out hold every cycle
    task automatic check_cycle();
        check_value("ahb_resp.hready", 32'(ahb_resp.hready), 32'd1);
        check_value("ahb_resp.hresp", 32'(ahb_resp.hresp), 32'(ahb_pkg::OKAY));
        check_value("gpio_out", 32'(gpio_out), gpio_model);
    endtask

    // read data is checked before the write of this data phase lands in the model
    task automatic check_data_phase(input txn_t t);
        if (is_active(t.addr.htrans) && !t.addr.hwrite)
            check_value("ahb_resp.hrdata", ahb_resp.hrdata, expected_read(t));
        if (is_active(t.addr.htrans) && t.addr.hwrite)
            apply_write(t);
    endtask

    initial
    begin
        void'($urandom(seed));
        checks       = 0;
        errors       = 0;
        gpio_model   = 32'h0;
        in_level     = '0;
        in_stable    = 0;
        last_gen     = '0;
        dphase_valid = 1'b0;
        HRESETn      = 1'b0;
        ahb_addr     = '0;
        hwdata       = 32'h0;
        gpio_in      = '0;

        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(negedge HCLK);
        // state straight out of reset
        check_cycle();
        check_value("ahb_resp.hrdata", ahb_resp.hrdata, 32'h0);

        for (int cyc = 0; cyc <= total_cycles; cyc++)
        begin
            @(posedge HCLK);
            // transfer from the last cycle enters its data phase
            dphase_valid = (pending.size() != 0);
            if (dphase_valid)
                dphase = pending.pop_front();
            // input pins move now and then
            if ((cyc % 8) == 0 && ($urandom % 2) == 1)
            begin
                in_level = gpio_width'($urandom);
                gpio_in <= in_level;
                in_stable = 0;
            end
            else
                in_stable++;
            if (cyc < init_cycles)
                make_fill(cyc, next_txn);
            else if (cyc < total_cycles)
                gen_random(next_txn);
            else
                next_txn = '0;
            if (dphase_valid && is_active(dphase.addr.htrans) && dphase.addr.hwrite)
                hwdata <= dphase.wdata;
            else
                hwdata <= $urandom;
            ahb_addr <= next_txn.addr;
            pending.push_back(next_txn);
            @(negedge HCLK);
            check_cycle();
            if (dphase_valid)
                check_data_phase(dphase);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: ahb_ram_subsystem.f
src/ahb_pkg.sv
src/soc_map_pkg.sv
src/dual_port_ram.sv
src/ahb_ram_slave.sv
src/ahb_gpio_slave.sv
src/ahb_decoder.sv
src/ahb_ram_subsystem.sv
verif/tb_ahb_ram_subsystem.sv

// File: Makefile
# Verilator build and run for the AHB-Lite RAM subsystem
# any variable below can be set on the command line

TOP       ?= tb_ahb_ram_subsystem
FILELIST  ?= ahb_ram_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(wildcard src/*.sv verif/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
